/* verilog/csi2_proto_pkg.sv */
package csi2_proto_pkg;

// Number of data lanes on the receive side.
localparam int LANES = 2;

// Leader byte of every HS burst, seen on each lane in the same cycle.
localparam logic [7 : 0] SYNC_BYTE = 8'hB8;

// Data identifier values handled by the receiver.
typedef enum logic [7 : 0]
{
  DT_FRAME_START = 8'h00,
  DT_FRAME_END   = 8'h01,
  DT_LINE_START  = 8'h02,
  DT_LINE_END    = 8'h03,
  DT_RAW8        = 8'h2A
} data_type_t;

// Data types up to this value are short packets without payload.
localparam logic [7 : 0] DT_SHORT_MAX = 8'h0F;

endpackage

/* verilog/csi2_rx_pkg.sv */
package csi2_rx_pkg;

// Packet decoder states.
typedef enum logic [2 : 0]
{
  ST_IDLE,
  ST_HDR0,
  ST_HDR1,
  ST_PAYLOAD,
  ST_CRC,
  ST_SKIP
} pkt_state_t;

// Two lane bytes merged into one word.
localparam int WORD_W     = 16;

localparam int FIFO_DEPTH = 8;

// Word count field of the packet header.
localparam int WC_W       = 16;

endpackage

/* verilog/csi2_lane_merge.sv */
`timescale 1ns/1ns

module csi2_lane_merge
(
  input                                          ref_clk_i,
  input                                          ref_srst_i,
  input        [7 : 0]                           lane0_data_i,
  input        [7 : 0]                           lane1_data_i,
  input        [csi2_proto_pkg::LANES - 1 : 0]   lane_valid_i,
  output logic [csi2_rx_pkg::WORD_W - 1 : 0]     word_o,
  output logic                                   word_valid_o,
  output logic                                   sof_o
);

import csi2_proto_pkg::*;

logic both_valid;
logic idle_q;
logic in_pkt;
logic sync_det;

assign both_valid = &lane_valid_i;

// Sync must follow at least one cycle without both lanes valid.
assign sync_det = both_valid && idle_q &&
                  ( lane0_data_i == SYNC_BYTE ) &&
                  ( lane1_data_i == SYNC_BYTE );

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      idle_q       <= 1'b1;
      in_pkt       <= 1'b0;
      sof_o        <= 1'b0;
      word_valid_o <= 1'b0;
    end
  else
    begin
      idle_q       <= !both_valid;
      sof_o        <= sync_det;
      word_valid_o <= in_pkt && both_valid;
      if( sync_det )
        in_pkt <= 1'b1;
      else
        if( !both_valid )
          in_pkt <= 1'b0;
    end

// Lane 1 forms the upper byte.
always_ff @( posedge ref_clk_i )
  word_o <= { lane1_data_i, lane0_data_i };

endmodule

/* verilog/csi2_pkt_fsm.sv */
`timescale 1ns/1ns

module csi2_pkt_fsm
(
  input                                        ref_clk_i,
  input                                        ref_srst_i,
  input        [csi2_rx_pkg::WORD_W - 1 : 0]   word_i,
  input                                        word_valid_i,
  input                                        sof_i,
  input                                        last_i,
  input        [1 : 0]                         keep_i,
  output logic                                 wc_load_o,
  output logic [csi2_rx_pkg::WC_W - 1 : 0]     wc_o,
  output logic                                 wc_dec_o,
  output logic                                 push_o,
  output logic [csi2_rx_pkg::WORD_W - 1 : 0]   push_data_o,
  output logic                                 push_user_o,
  output logic                                 push_last_o,
  output logic [1 : 0]                         push_keep_o,
  output logic                                 err_dt_o
);

import csi2_proto_pkg::*;
import csi2_rx_pkg::*;

pkt_state_t   state;
pkt_state_t   state_next;
data_type_t   dt;
logic [7 : 0] wc_lo;
logic         user_armed;
logic         arm_user;
logic         clear_user;
logic         hdr_done;
logic         is_short;
logic         skip_pkt;
logic         payload_word;

assign hdr_done     = ( state == ST_HDR1 ) && word_valid_i;
assign is_short     = dt <= DT_SHORT_MAX;
assign skip_pkt     = hdr_done && !is_short && ( dt != DT_RAW8 );
assign payload_word = ( state == ST_PAYLOAD ) && word_valid_i;

// Word count high byte rides on lane 0 of the second header word.
assign wc_o      = { word_i[7 : 0], wc_lo };
assign wc_load_o = hdr_done && ( dt == DT_RAW8 ) && ( wc_o != '0 );
assign wc_dec_o  = payload_word;

always_comb
  begin
    arm_user   = 1'b0;
    clear_user = payload_word;
    if( hdr_done && is_short )
      case( dt )
        DT_FRAME_START:
          arm_user = 1'b1;
        DT_FRAME_END:
          clear_user = 1'b1;
        // Line boundaries come from the RAW8 word count.
        default:
          clear_user = payload_word;
      endcase
  end

always_comb
  begin
    state_next = state;
    case( state )
      ST_IDLE:
        state_next = ST_IDLE;
      ST_HDR0:
        if( word_valid_i )
          state_next = ST_HDR1;
        else
          state_next = ST_IDLE;
      ST_HDR1:
        if( !word_valid_i || is_short )
          state_next = ST_IDLE;
        else
          if( skip_pkt )
            state_next = ST_SKIP;
          else
            if( wc_load_o )
              state_next = ST_PAYLOAD;
            else
              state_next = ST_CRC;
      ST_PAYLOAD:
        if( !word_valid_i )
          state_next = ST_IDLE;
        else
          if( last_i )
            state_next = ST_CRC;
      ST_CRC:
        state_next = ST_IDLE;
      ST_SKIP:
        if( !word_valid_i )
          state_next = ST_IDLE;
      default:
        state_next = ST_IDLE;
    endcase
    // A sync word restarts decoding.
    if( sof_i )
      state_next = ST_HDR0;
  end

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      state      <= ST_IDLE;
      user_armed <= 1'b0;
      push_o     <= 1'b0;
      err_dt_o   <= 1'b0;
    end
  else
    begin
      state    <= state_next;
      push_o   <= payload_word;
      err_dt_o <= skip_pkt;
      if( arm_user )
        user_armed <= 1'b1;
      else
        if( clear_user )
          user_armed <= 1'b0;
    end

always_ff @( posedge ref_clk_i )
  begin
    if( ( state == ST_HDR0 ) && word_valid_i )
      begin
        dt    <= data_type_t'( word_i[7 : 0] );
        wc_lo <= word_i[15 : 8];
      end
    push_data_o <= word_i;
    push_user_o <= user_armed;
    push_last_o <= last_i;
    push_keep_o <= keep_i;
  end

endmodule

/* verilog/csi2_wc_counter.sv */
`timescale 1ns/1ns

module csi2_wc_counter
(
  input                                   ref_clk_i,
  input                                   ref_srst_i,
  input                                   load_i,
  input        [csi2_rx_pkg::WC_W - 1 : 0] wc_i,
  input                                   dec_i,
  output logic                            last_o,
  output logic [1 : 0]                    keep_o
);

import csi2_rx_pkg::*;

// Payload bytes still to come, the current word included.
logic [WC_W - 1 : 0] remain;

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    remain <= '0;
  else
    if( load_i )
      remain <= wc_i;
    else
      if( dec_i )
        begin
          if( remain > WC_W'( 2 ) )
            remain <= remain - WC_W'( 2 );
          else
            remain <= '0;
        end

assign last_o = remain <= WC_W'( 2 );

// Odd count leaves a lone byte on lane 0.
assign keep_o = ( remain == WC_W'( 1 ) ) ? 2'b01 : 2'b11;

endmodule

/* verilog/csi2_pixel_fifo.sv */
`timescale 1ns/1ns

module csi2_pixel_fifo
(
  input                                        ref_clk_i,
  input                                        ref_srst_i,
  input                                        push_i,
  input        [csi2_rx_pkg::WORD_W - 1 : 0]   data_i,
  input                                        user_i,
  input                                        last_i,
  input        [1 : 0]                         keep_i,
  input                                        tready_i,
  output logic [csi2_rx_pkg::WORD_W - 1 : 0]   tdata_o,
  output logic                                 tvalid_o,
  output logic [1 : 0]                         tkeep_o,
  output logic                                 tuser_o,
  output logic                                 tlast_o,
  output logic                                 overflow_o
);

import csi2_rx_pkg::*;

// One beat is user, last, keep and data packed together.
logic [WORD_W + 3 : 0]             mem [FIFO_DEPTH];
logic [$clog2( FIFO_DEPTH ) - 1 : 0] wr_ptr;
logic [$clog2( FIFO_DEPTH ) - 1 : 0] rd_ptr;
logic [$clog2( FIFO_DEPTH ) : 0]     count;
logic                              full;
logic                              wr_en;
logic                              rd_en;

assign full     = count == FIFO_DEPTH;
assign wr_en    = push_i && !full;
assign tvalid_o = count != '0;
assign rd_en    = tvalid_o && tready_i;

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end
  else
    begin
      if( wr_en )
        wr_ptr <= wr_ptr + 1'b1;
      if( rd_en )
        rd_ptr <= rd_ptr + 1'b1;
      case( { wr_en, rd_en } )
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Sticky until reset.
      if( push_i && full )
        overflow_o <= 1'b1;
    end

always_ff @( posedge ref_clk_i )
  if( wr_en )
    mem[wr_ptr] <= { user_i, last_i, keep_i, data_i };

// Head entry stays put until the handshake moves rd_ptr.
assign { tuser_o, tlast_o, tkeep_o, tdata_o } = mem[rd_ptr];

endmodule

/* verilog/csi2_rx.sv */
`timescale 1ns/1ns

module csi2_rx
(
  input                                          ref_clk_i,
  input                                          ref_srst_i,
  input        [7 : 0]                           lane0_data_i,
  input        [7 : 0]                           lane1_data_i,
  input        [csi2_proto_pkg::LANES - 1 : 0]   lane_valid_i,
  input                                          video_tready_i,
  output logic [csi2_rx_pkg::WORD_W - 1 : 0]     video_tdata_o,
  output logic                                   video_tvalid_o,
  output logic [1 : 0]                           video_tkeep_o,
  output logic                                   video_tuser_o,
  output logic                                   video_tlast_o,
  output logic                                   err_dt_o,
  output logic                                   overflow_o
);

import csi2_rx_pkg::*;

logic [WORD_W - 1 : 0] word;
logic                  word_valid;
logic                  sof;
logic                  wc_load;
logic [WC_W - 1 : 0]   wc;
logic                  wc_dec;
logic                  wc_last;
logic [1 : 0]          wc_keep;
logic                  push;
logic [WORD_W - 1 : 0] push_data;
logic                  push_user;
logic                  push_last;
logic [1 : 0]          push_keep;

csi2_lane_merge csi2_lane_merge (
  .ref_clk_i    ( ref_clk_i    ),
  .ref_srst_i   ( ref_srst_i   ),
  .lane0_data_i ( lane0_data_i ),
  .lane1_data_i ( lane1_data_i ),
  .lane_valid_i ( lane_valid_i ),
  .word_o       ( word         ),
  .word_valid_o ( word_valid   ),
  .sof_o        ( sof          )
);

csi2_pkt_fsm csi2_pkt_fsm (
  .ref_clk_i    ( ref_clk_i    ),
  .ref_srst_i   ( ref_srst_i   ),
  .word_i       ( word         ),
  .word_valid_i ( word_valid   ),
  .sof_i        ( sof          ),
  .last_i       ( wc_last      ),
  .keep_i       ( wc_keep      ),
  .wc_load_o    ( wc_load      ),
  .wc_o         ( wc           ),
  .wc_dec_o     ( wc_dec       ),
  .push_o       ( push         ),
  .push_data_o  ( push_data    ),
  .push_user_o  ( push_user    ),
  .push_last_o  ( push_last    ),
  .push_keep_o  ( push_keep    ),
  .err_dt_o     ( err_dt_o     )
);

csi2_wc_counter csi2_wc_counter (
  .ref_clk_i    ( ref_clk_i    ),
  .ref_srst_i   ( ref_srst_i   ),
  .load_i       ( wc_load      ),
  .wc_i         ( wc           ),
  .dec_i        ( wc_dec       ),
  .last_o       ( wc_last      ),
  .keep_o       ( wc_keep      )
);

csi2_pixel_fifo csi2_pixel_fifo (
  .ref_clk_i    ( ref_clk_i      ),
  .ref_srst_i   ( ref_srst_i     ),
  .push_i       ( push           ),
  .data_i       ( push_data      ),
  .user_i       ( push_user      ),
  .last_i       ( push_last      ),
  .keep_i       ( push_keep      ),
  .tready_i     ( video_tready_i ),
  .tdata_o      ( video_tdata_o  ),
  .tvalid_o     ( video_tvalid_o ),
  .tkeep_o      ( video_tkeep_o  ),
  .tuser_o      ( video_tuser_o  ),
  .tlast_o      ( video_tlast_o  ),
  .overflow_o   ( overflow_o     )
);

endmodule

/* dv/csi2_rx_chk.sv */
`timescale 1ns/1ns

module csi2_rx_chk
(
  input                                  ref_clk_i,
  input                                  ref_srst_i,
  input  [csi2_rx_pkg::WORD_W - 1 : 0]   video_tdata_i,
  input                                  video_tvalid_i,
  input  [1 : 0]                         video_tkeep_i,
  input                                  video_tuser_i,
  input                                  video_tlast_i,
  input                                  video_tready_i,
  input                                  overflow_i
);

// Raised by any failing assertion below.
logic fail_seen = 1'b0;

valid_low_in_reset : assert property
  ( @( posedge ref_clk_i ) ( ref_srst_i && $past( ref_srst_i ) ) |-> !video_tvalid_i )
  else
    begin
      fail_seen = 1'b1;
      $error( "video_tvalid_o high during reset" );
    end

// Beat contents hold while the sink stalls.
hold_on_stall : assert property
  ( @( posedge ref_clk_i ) disable iff ( ref_srst_i )
    ( video_tvalid_i && !video_tready_i ) |=>
      ( video_tvalid_i && $stable( video_tdata_i ) && $stable( video_tkeep_i ) &&
        $stable( video_tuser_i ) && $stable( video_tlast_i ) ) )
  else
    begin
      fail_seen = 1'b1;
      $error( "Video beat changed while stalled" );
    end

keep_nonzero : assert property
  ( @( posedge ref_clk_i ) disable iff ( ref_srst_i )
    video_tvalid_i |-> ( video_tkeep_i != 2'b00 ) )
  else
    begin
      fail_seen = 1'b1;
      $error( "video_tkeep_o zero on a valid beat" );
    end

no_overflow : assert property
  ( @( posedge ref_clk_i ) disable iff ( ref_srst_i ) !overflow_i )
  else
    begin
      fail_seen = 1'b1;
      $error( "Pixel FIFO overflow" );
    end

endmodule

bind csi2_rx csi2_rx_chk rx_chk
(
  .ref_clk_i      ( ref_clk_i      ),
  .ref_srst_i     ( ref_srst_i     ),
  .video_tdata_i  ( video_tdata_o  ),
  .video_tvalid_i ( video_tvalid_o ),
  .video_tkeep_i  ( video_tkeep_o  ),
  .video_tuser_i  ( video_tuser_o  ),
  .video_tlast_i  ( video_tlast_o  ),
  .video_tready_i ( video_tready_i ),
  .overflow_i     ( overflow_o     )
);

/* dv/csi2_rx_tb.sv */
`timescale 1ns/1ns

module csi2_rx_tb;

import csi2_proto_pkg::*;
import csi2_rx_pkg::*;

// Stimulus spans a few hundred cycles.
localparam int MAX_CYCLES = 4000;

logic                  ref_clk = 1'b0;
logic                  ref_srst;
logic [7 : 0]          lane0_data;
logic [7 : 0]          lane1_data;
logic [LANES - 1 : 0]  lane_valid;
logic                  video_tready;
logic [WORD_W - 1 : 0] video_tdata;
logic                  video_tvalid;
logic [1 : 0]          video_tkeep;
logic                  video_tuser;
logic                  video_tlast;
logic                  err_dt;
logic                  overflow;

// Expected beat is user, last, keep and data.
logic [WORD_W + 3 : 0] exp_q [$];
logic [31 : 0]         rng_state;
logic                  rand_ready;
logic                  user_armed;
int                    low_run;
int                    cycles;
int                    err_seen;
int                    err_expected;

csi2_rx uut (
  .ref_clk_i      ( ref_clk      ),
  .ref_srst_i     ( ref_srst     ),
  .lane0_data_i   ( lane0_data   ),
  .lane1_data_i   ( lane1_data   ),
  .lane_valid_i   ( lane_valid   ),
  .video_tready_i ( video_tready ),
  .video_tdata_o  ( video_tdata  ),
  .video_tvalid_o ( video_tvalid ),
  .video_tkeep_o  ( video_tkeep  ),
  .video_tuser_o  ( video_tuser  ),
  .video_tlast_o  ( video_tlast  ),
  .err_dt_o       ( err_dt       ),
  .overflow_o     ( overflow     )
);

initial
  forever #4 ref_clk = ~ref_clk;

function automatic logic [31 : 0] xorshift32( input logic [31 : 0] x );
  logic [31 : 0] y;
  y = x ^ ( x << 13 );
  y = y ^ ( y >> 17 );
  return y ^ ( y << 5 );
endfunction

task automatic abort_run();
  $display( "TEST FAILED" );
  $fatal( 1 );
endtask

task automatic report_mismatch( input string name, input logic [15 : 0] got,
                                input logic [15 : 0] want );
  $display( "[FAIL] %s got 0x%0h expected 0x%0h", name, got, want );
  abort_run();
endtask

task automatic check_beat();
  logic [WORD_W + 3 : 0] beat;
  logic [WORD_W - 1 : 0] mask;
  if( exp_q.size() == 0 )
    begin
      $display( "Beat accepted on the video stream with none expected" );
      abort_run();
    end
  else
    begin
      beat = exp_q.pop_front();
      // Lone byte of an odd line sits in the low half.
      mask = beat[17] ? 16'hFFFF : 16'h00FF;
      assert( ( video_tdata & mask ) == beat[15 : 0] )
        else report_mismatch( "video_tdata", video_tdata & mask, beat[15 : 0] );
      assert( video_tkeep == beat[17 : 16] )
        else report_mismatch( "video_tkeep", 16'( video_tkeep ), 16'( beat[17 : 16] ) );
      assert( video_tlast == beat[18] )
        else report_mismatch( "video_tlast", 16'( video_tlast ), 16'( beat[18] ) );
      assert( video_tuser == beat[19] )
        else report_mismatch( "video_tuser", 16'( video_tuser ), 16'( beat[19] ) );
    end
endtask

task automatic send_word( input logic [7 : 0] b0, input logic [7 : 0] b1 );
  lane0_data = b0;
  lane1_data = b1;
  lane_valid = 2'b11;
  @( negedge ref_clk );
endtask

task automatic send_packet( input logic [7 : 0] dt, input int wc, input int line_no );
  logic [7 : 0] b0;
  logic [7 : 0] b1;
  logic         last;
  logic [1 : 0] keep;
  send_word( SYNC_BYTE, SYNC_BYTE );
  send_word( dt, wc[7 : 0] );
  // ECC byte is ignored by the receiver.
  send_word( wc[15 : 8], 8'h5A );
  if( dt == DT_FRAME_START )
    user_armed = 1'b1;
  if( dt == DT_FRAME_END )
    user_armed = 1'b0;
  if( dt > DT_SHORT_MAX )
    begin
      if( dt != DT_RAW8 )
        err_expected++;
      for( int i = 0; i < wc; i += 2 )
        begin
          b0   = 8'( line_no * 29 + i * 7 + 3 );
          b1   = ( i + 1 < wc ) ? 8'( line_no * 29 + i * 7 + 10 ) : 8'h00;
          last = i + 2 >= wc;
          keep = ( i + 1 < wc ) ? 2'b11 : 2'b01;
          if( dt == DT_RAW8 )
            begin
              exp_q.push_back( { user_armed, last, keep, b1, b0 } );
              user_armed = 1'b0;
            end
          send_word( b0, b1 );
        end
      send_word( 8'hC3, 8'h3C );
    end
  lane_valid = 2'b00;
  lane0_data = 8'h00;
  lane1_data = 8'h00;
  repeat( 3 ) @( negedge ref_clk );
endtask

task automatic wait_drain();
  while( exp_q.size() != 0 )
    @( negedge ref_clk );
  @( negedge ref_clk );
  assert( !video_tvalid )
    else report_mismatch( "video_tvalid", 16'( video_tvalid ), 16'h0 );
  assert( err_seen == err_expected )
    else report_mismatch( "err_dt_o pulses", 16'( err_seen ), 16'( err_expected ) );
endtask

always @( negedge ref_clk )
  begin
    cycles++;
    if( cycles >= MAX_CYCLES )
      begin
        $display( "Run stopped after %0d cycles without finishing", MAX_CYCLES );
        abort_run();
      end
    else
      if( uut.rx_chk.fail_seen )
        begin
          $display( "A bound assertion on the video stream failed" );
          abort_run();
        end
      else
        begin
          rng_state = xorshift32( rng_state );
          // Ready stays low for at most three cycles in a row.
          if( rand_ready && ( low_run < 3 ) && rng_state[7] )
            begin
              video_tready = 1'b0;
              low_run++;
            end
          else
            begin
              video_tready = 1'b1;
              low_run      = 0;
            end
          if( err_dt )
            err_seen++;
          if( video_tvalid && video_tready )
            check_beat();
        end
  end

initial
  begin
    ref_srst     = 1'b1;
    lane0_data   = 8'h00;
    lane1_data   = 8'h00;
    lane_valid   = 2'b00;
    video_tready = 1'b1;
    rng_state    = 32'd43001;
    rand_ready   = 1'b0;
    user_armed   = 1'b0;
    low_run      = 0;
    cycles       = 0;
    err_seen     = 0;
    err_expected = 0;
    repeat( 4 ) @( posedge ref_clk );
    @( negedge ref_clk );
    ref_srst = 1'b0;
    assert( !video_tvalid )
      else report_mismatch( "video_tvalid", 16'( video_tvalid ), 16'h0 );

    // Steady ready with even and odd lines inside and after a frame.
    send_packet( DT_FRAME_START, 1, 0 );
    send_packet( DT_LINE_START, 0, 0 );
    send_packet( DT_RAW8, 16, 0 );
    send_packet( DT_LINE_END, 0, 0 );
    wait_drain();
    send_packet( DT_RAW8, 11, 1 );
    wait_drain();
    // Frame end drops a tuser that no line has taken yet.
    send_packet( DT_FRAME_START, 1, 0 );
    send_packet( DT_FRAME_END, 1, 0 );
    send_packet( DT_RAW8, 8, 2 );
    wait_drain();

    // New frame under random back-pressure.
    rand_ready = 1'b1;
    send_packet( DT_FRAME_START, 2, 0 );
    for( int n = 3; n < 11; n++ )
      begin
        send_packet( DT_RAW8, 6 + n, n );
        wait_drain();
      end

    // Unknown long type is skipped.
    send_packet( 8'h2B, 10, 11 );
    wait_drain();
    send_packet( DT_RAW8, 13, 12 );
    wait_drain();

    if( ( exp_q.size() == 0 ) && !overflow )
      begin
        $display( "TEST OK" );
        $finish;
      end
    else
      report_mismatch( "overflow_o", 16'( overflow ), 16'h0 );
  end

endmodule

/* list.f */
verilog/csi2_proto_pkg.sv
verilog/csi2_rx_pkg.sv
verilog/csi2_lane_merge.sv
verilog/csi2_pkt_fsm.sv
verilog/csi2_wc_counter.sv
verilog/csi2_pixel_fifo.sv
verilog/csi2_rx.sv
dv/csi2_rx_chk.sv
dv/csi2_rx_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module csi2_rx_tb -f list.f -o csi2_rx_sim

sim_out=$(./obj_dir/csi2_rx_sim +verilator+error+limit+100 2>&1 || true)
echo "$sim_out"

if grep -qx "TEST OK" <<< "$sim_out"; then
  exit 0
fi
exit 1
